// ==== sample_player_top.f ====
rtl/sample_player_pkg.sv
rtl/sample_loader.sv
rtl/sample_store.sv
rtl/wav_header_decode.sv
rtl/sample_stepper.sv
rtl/pcm_output.sv
rtl/sample_player_top.sv
bench/sample_player_tb.sv

// ==== Bender.yml ====
package:
  name: sample_player

sources:
  - rtl/sample_player_pkg.sv
  - rtl/sample_loader.sv
  - rtl/sample_store.sv
  - rtl/wav_header_decode.sv
  - rtl/sample_stepper.sv
  - rtl/pcm_output.sv
  - rtl/sample_player_top.sv
  - target: simulation
    files:
      - bench/sample_player_tb.sv

// ==== bench/sample_player_tb.sv ====
module sample_player_tb import sample_player_pkg::*; ();

	logic        clk_sys;
	logic        rst;
	logic        ioctl_download;
	logic        ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [7:0]  ioctl_index;
	logic [7:0]  ioctl_dout;
	logic        play;
	logic [15:0] audio_out;
	logic        audio_strobe;
	logic        wav_loaded;
	logic        format_valid;
	logic        fmt_error;

	logic [31:0] lfsr;
	logic [7:0]  image [0:(1 << STORE_AW) - 1];  // file as the host sends it
	int          img_len;
	logic [15:0] ref_samples[$];  // left channel in file order
	logic [15:0] expect_q[$];
	int          errors;
	int          checks;
	int          tests;
	int          strobe_cnt;

	sample_player_top uut (
		.clk_sys, .rst, .ioctl_download, .ioctl_wr, .ioctl_addr, .ioctl_index, .ioctl_dout,
		.play, .audio_out, .audio_strobe, .wav_loaded, .format_valid, .fmt_error
	);

	always #4 clk_sys = ~clk_sys;

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		assert (got == expected) else begin
			$display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, expected);
			errors++;
		end
	endtask

	task automatic put_le(input int off, input int n, input logic [31:0] v);
		for (int i = 0; i < n; i++)
			image[off + i] = v[8*i +: 8];
	endtask

	task automatic build_wav(input int channels, input int bits, input int rate, input int frames);
		int         bps;
		int         data_len;
		int         base;
		logic [7:0] byte_v;
		bps = bits / 8;
		data_len = frames * channels * bps;
		put_le(0, 4, 32'h4646_4952);   // RIFF
		put_le(4, 4, 36 + data_len);
		put_le(8, 4, 32'h4556_4157);   // WAVE
		put_le(12, 4, 32'h2074_6d66);  // fmt chunk id
		put_le(16, 4, 16);
		put_le(20, 2, 1);              // plain pcm
		put_le(22, 2, channels);
		put_le(24, 4, rate);
		put_le(28, 4, rate * channels * bps);
		put_le(32, 2, channels * bps);
		put_le(34, 2, bits);
		put_le(36, 4, 32'h6174_6164);  // data
		put_le(40, 4, data_len);
		img_len = HDR_BYTES + data_len;
		ref_samples.delete();
		for (int f = 0; f < frames; f++) begin
			base = HDR_BYTES + f * channels * bps;
			for (int k = 0; k < channels * bps; k++) begin
				random_byte(byte_v);
				image[base + k] = byte_v;
			end
			if (bits == 8)
				ref_samples.push_back(16'((int'(image[base]) - 128) * 256)); // midscale is zero
			else if (bits == 16)
				ref_samples.push_back({image[base + 1], image[base]}); // left only
		end
	endtask

	task automatic download_image();
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		ioctl_index <= WAV_INDEX;
		for (int a = 0; a < img_len; a++) begin
			@(posedge clk_sys);
			ioctl_wr <= 1'b1;
			ioctl_addr <= 25'(a);
			ioctl_dout <= image[a];
		end
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
	endtask

	task automatic wait_decoded(input int limit);
		int cyc;
		cyc = 0;
		while (!(format_valid || fmt_error) && cyc < limit) begin
			@(posedge clk_sys);
			cyc++;
		end
		if (!(format_valid || fmt_error)) begin
			$display("timeout: header decode did not finish within %0d cycles", limit);
			errors++;
		end
	endtask

	task automatic wait_strobes(input int target, input int limit);
		int cyc;
		cyc = 0;
		while (strobe_cnt < target && cyc < limit) begin
			@(posedge clk_sys);
			cyc++;
		end
		if (strobe_cnt < target) begin
			$display("timeout: only %0d of %0d audio strobes came", strobe_cnt, target);
			errors++;
		end
	endtask

	task automatic load_and_play(input int channels, input int bits, input int rate,
		input int frames);
		@(posedge clk_sys);
		play <= 1'b0;
		build_wav(channels, bits, rate, frames);
		expect_q = ref_samples;
		download_image();
		wait_decoded(400);
		check_value("wav_loaded", wav_loaded, 1);
		check_value("format_valid", format_valid, 1);
		@(posedge clk_sys);
		play <= 1'b1;
	endtask

	task automatic report_test(input string name, input int start_err);
		tests++;
		$display("test %0d %s: %s", tests, name, (errors == start_err) ? "pass" : "fail");
	endtask

	// every strobe while playing takes the next expected sample
	always @(negedge clk_sys) begin
		logic [15:0] expected;
		if (!rst && audio_strobe && play) begin
			strobe_cnt++;
			if (expect_q.size() == 0) begin
				$display("audio strobe at %0t with no sample expected", $time);
				errors++;
			end else begin
				expected = expect_q.pop_front();
				expect_q.push_back(expected); // playback loops
				check_value("audio_out", audio_out, expected);
			end
		end
	end

	initial begin
		int base;
		int start_err;
		clk_sys = 1'b0;
		rst = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_index = '0;
		ioctl_dout = '0;
		play = 1'b0;
		lfsr = 32'h3990;
		errors = 0;
		checks = 0;
		tests = 0;
		strobe_cnt = 0;
		repeat (2) @(posedge clk_sys);
		rst <= 1'b0;

		start_err = errors;
		repeat (20) begin
			@(negedge clk_sys);
			check_value("wav_loaded", wav_loaded, 0);
			check_value("format_valid", format_valid, 0);
			check_value("fmt_error", fmt_error, 0);
			check_value("audio_strobe", audio_strobe, 0);
			check_value("audio_out", audio_out, 0);
		end
		report_test("quiet after reset", start_err);

		start_err = errors;
		load_and_play(1, 8, 250000, 16);
		base = strobe_cnt;
		wait_strobes(base + 16, 1000);
		report_test("8-bit mono playback", start_err);

		start_err = errors;
		load_and_play(2, 16, 100000, 12);
		base = strobe_cnt;
		wait_strobes(base + 12, 1200);
		report_test("16-bit stereo left channel", start_err);

		start_err = errors;
		load_and_play(1, 8, 400000, 5);
		base = strobe_cnt;
		wait_strobes(base + 12, 800); // wraps twice
		report_test("loop at end of data", start_err);

		start_err = errors;
		@(posedge clk_sys);
		play <= 1'b0;
		@(posedge clk_sys);
		expect_q = ref_samples;
		repeat (30) begin
			@(negedge clk_sys);
			check_value("audio_strobe", audio_strobe, 0);
			check_value("audio_out", audio_out, 0);
		end
		@(posedge clk_sys);
		play <= 1'b1;
		base = strobe_cnt;
		wait_strobes(base + 3, 300);
		report_test("pause and restart", start_err);

		start_err = errors;
		@(posedge clk_sys);
		play <= 1'b0;
		build_wav(1, 24, 250000, 4);
		expect_q.delete();
		download_image();
		wait_decoded(400);
		check_value("fmt_error", fmt_error, 1);
		check_value("format_valid", format_valid, 0);
		base = strobe_cnt;
		@(posedge clk_sys);
		play <= 1'b1;
		repeat (150) @(posedge clk_sys);
		check_value("strobe count", strobe_cnt, base);
		play <= 1'b0;
		report_test("24-bit format error", start_err);

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== rtl/sample_player_top.sv ====
module sample_player_top import sample_player_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst,
	input  logic        ioctl_download,
	input  logic        ioctl_wr,
	input  logic [24:0] ioctl_addr,
	input  logic [7:0]  ioctl_index,
	input  logic [7:0]  ioctl_dout,
	input  logic        play,
	output logic [15:0] audio_out,
	output logic        audio_strobe,
	output logic        wav_loaded,
	output logic        format_valid,
	output logic        fmt_error
);

	logic                wr_en;
	logic [STORE_AW-1:0] wr_addr;
	logic [7:0]          wr_data;
	logic                rd_req;
	logic [STORE_AW-1:0] rd_addr;
	logic                rd_ack;
	logic [7:0]          rd_data;
	logic                step_req;
	logic [STORE_AW-1:0] step_addr;
	logic                step_ack;
	logic [7:0]          step_data;
	wav_format_t         fmt;
	pcm_t                sample;

	sample_loader loader (
		.clk_sys, .rst, .ioctl_download, .ioctl_wr, .ioctl_addr, .ioctl_index, .ioctl_dout,
		.wr_en, .wr_addr, .wr_data, .wav_loaded
	);

	sample_store store (
		.clk_sys, .rst, .wr_en, .wr_addr, .wr_data, .rd_req, .rd_addr, .rd_ack, .rd_data
	);

	wav_header_decode decode (
		.clk_sys, .rst, .wav_loaded, .rd_ack, .rd_data, .step_req, .step_addr,
		.rd_req, .rd_addr, .step_ack, .step_data, .fmt, .format_valid, .fmt_error
	);

	sample_stepper stepper (
		.clk_sys, .rst, .play, .fmt, .format_valid, .step_ack, .step_data,
		.step_req, .step_addr, .sample
	);

	pcm_output out_stage (
		.clk_sys, .rst, .play, .sample, .audio_out, .audio_strobe
	);

endmodule

// ==== rtl/pcm_output.sv ====
module pcm_output import sample_player_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst,
	input  logic        play,
	input  pcm_t        sample,
	output logic [15:0] audio_out,
	output logic        audio_strobe
);

	logic [15:0] audio_q;
	logic [15:0] conv;

	// 8-bit wav is unsigned, move it up and flip to two's complement
	assign conv = sample.bits16 ? sample.raw : {~sample.raw[7], sample.raw[6:0], 8'h00};

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			audio_q <= '0;
			audio_strobe <= 1'b0;
		end else begin
			audio_strobe <= play && sample.valid;
			if (!play)
				audio_q <= '0; // no stale value on restart
			else if (sample.valid)
				audio_q <= conv;
		end
	end

	assign audio_out = play ? audio_q : 16'h0000;

endmodule

// ==== rtl/sample_stepper.sv ====
module sample_stepper import sample_player_pkg::*; (
	input  logic                clk_sys,
	input  logic                rst,
	input  logic                play,
	input  wav_format_t         fmt,
	input  logic                format_valid,
	input  logic                step_ack,
	input  logic [7:0]          step_data,
	output logic                step_req,
	output logic [STORE_AW-1:0] step_addr,
	output pcm_t                sample
);

	step_state_e state;

	logic [32:0] acc;
	logic [33:0] sum;
	logic        tick;
	logic        done;
	logic [31:0] offset;  // byte offset into the data chunk
	logic [7:0]  lo;
	logic [7:0]  hi;
	logic        valid_q;

	function automatic logic [31:0] advance(input logic [31:0] off, input logic [1:0] n,
		input logic [31:0] len);
		logic [32:0] nxt;
		nxt = off + n;
		return (nxt >= {1'b0, len}) ? 32'd0 : nxt[31:0]; // loop at end of data
	endfunction

	assign sum = acc + fmt.sample_rate;
	assign tick = (sum >= 34'(CLK_HZ));
	assign done = (step_ack == step_req);

	assign sample.valid = valid_q;
	assign sample.bits16 = fmt.bits16;
	assign sample.raw = fmt.bits16 ? {hi, lo} : {8'h00, lo};

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state <= step_idle;
			step_req <= 1'b0;
			acc <= '0;
			offset <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			if (!play || !format_valid) begin
				state <= step_idle;
				acc <= '0;
				offset <= '0;
			end else begin
				// during a fetch the excess stays put until wait_tick
				if (state != step_idle && state != step_wait_tick && !tick)
					acc <= sum[32:0];
				case (state)
					step_idle: if (done)
						state <= step_wait_tick; // nothing left in flight
					step_wait_tick: begin
						if (tick) begin
							acc <= sum[32:0] - 33'(CLK_HZ);
							step_addr <= STORE_AW'(HDR_BYTES) + offset[STORE_AW-1:0];
							step_req <= ~step_req;
							offset <= advance(offset, 2'd1, fmt.data_len);
							state <= step_fetch_lo;
						end else begin
							acc <= sum[32:0];
						end
					end
					step_fetch_lo: if (done) begin
						lo <= step_data;
						if (fmt.bits16) begin
							step_addr <= STORE_AW'(HDR_BYTES) + offset[STORE_AW-1:0];
							step_req <= ~step_req;
							offset <= advance(offset, 2'd1, fmt.data_len);
							state <= step_fetch_hi;
						end else if (fmt.stereo) begin
							step_addr <= STORE_AW'(HDR_BYTES) + offset[STORE_AW-1:0];
							step_req <= ~step_req;
							offset <= advance(offset, 2'd1, fmt.data_len);
							state <= step_skip;
						end else begin
							valid_q <= 1'b1;
							state <= step_wait_tick;
						end
					end
					step_fetch_hi: if (done) begin
						hi <= step_data;
						if (fmt.stereo) begin
							step_addr <= STORE_AW'(HDR_BYTES) + offset[STORE_AW-1:0];
							step_req <= ~step_req;
							offset <= advance(offset, 2'd2, fmt.data_len); // whole right word
							state <= step_skip;
						end else begin
							valid_q <= 1'b1;
							state <= step_wait_tick;
						end
					end
					default: if (done) begin // skip read of the right channel
						valid_q <= 1'b1;
						state <= step_wait_tick;
					end
				endcase
			end
		end
	end

endmodule

// ==== rtl/wav_header_decode.sv ====
module wav_header_decode import sample_player_pkg::*; (
	input  logic                clk_sys,
	input  logic                rst,
	input  logic                wav_loaded,
	input  logic                rd_ack,
	input  logic [7:0]          rd_data,
	input  logic                step_req,
	input  logic [STORE_AW-1:0] step_addr,
	output logic                rd_req,
	output logic [STORE_AW-1:0] rd_addr,
	output logic                step_ack,
	output logic [7:0]          step_data,
	output wav_format_t         fmt,
	output logic                format_valid,
	output logic                fmt_error
);

	decode_state_e state;

	logic        loaded_q;
	logic        dec_req;
	logic        phase;     // parity offset between stepper and store toggles
	logic [3:0]  idx;
	logic [15:0] channels;
	logic [7:0]  bits;
	logic        got_byte;

	// header byte for each of the 11 reads
	function automatic logic [STORE_AW-1:0] hdr_offset(input logic [3:0] i);
		case (i)
			4'd0:    return STORE_AW'(22);
			4'd1:    return STORE_AW'(23);
			4'd2:    return STORE_AW'(24);
			4'd3:    return STORE_AW'(25);
			4'd4:    return STORE_AW'(26);
			4'd5:    return STORE_AW'(27);
			4'd6:    return STORE_AW'(34);
			4'd7:    return STORE_AW'(40);
			4'd8:    return STORE_AW'(41);
			4'd9:    return STORE_AW'(42);
			default: return STORE_AW'(43);
		endcase
	endfunction

	assign got_byte = (state == dec_wait_ack) && (rd_ack == dec_req);

	assign rd_req = (state == dec_ready) ? (step_req ^ phase) : dec_req;
	assign rd_addr = (state == dec_ready) ? step_addr : hdr_offset(idx);
	assign step_ack = rd_ack ^ phase;
	assign step_data = rd_data;

	assign format_valid = (state == dec_ready);
	assign fmt_error = (state == dec_bad);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state <= dec_idle;
			loaded_q <= 1'b0;
			dec_req <= 1'b0;
			phase <= 1'b0;
			idx <= '0;
		end else begin
			loaded_q <= wav_loaded;
			case (state)
				dec_idle: if (wav_loaded && !loaded_q) begin
					idx <= '0;
					state <= dec_fetch;
				end
				dec_fetch: begin
					dec_req <= ~dec_req;
					state <= dec_wait_ack;
				end
				dec_wait_ack: if (got_byte) begin
					if (idx == 4'd10) begin
						state <= dec_check;
					end else begin
						idx <= idx + 4'd1; // next read goes out right away
						dec_req <= ~dec_req;
					end
				end
				dec_check: begin
					if (bits == 8'd8 || bits == 8'd16) begin
						phase <= dec_req ^ step_req; // hand over with no edge on rd_req
						state <= dec_ready;
					end else begin
						state <= dec_bad;
					end
				end
				default: ;
			endcase
			if (!wav_loaded && loaded_q) begin
				state <= dec_idle;
				if (state == dec_ready)
					dec_req <= step_req ^ phase; // take the port back where it stands
			end
		end
	end

	// header fields, little-endian
	always_ff @(posedge clk_sys) begin
		if (got_byte) begin
			case (idx)
				4'd0:    channels[7:0] <= rd_data;
				4'd1:    channels[15:8] <= rd_data;
				4'd2:    fmt.sample_rate[7:0] <= rd_data;
				4'd3:    fmt.sample_rate[15:8] <= rd_data;
				4'd4:    fmt.sample_rate[23:16] <= rd_data;
				4'd5:    fmt.sample_rate[31:24] <= rd_data;
				4'd6:    bits <= rd_data;
				4'd7:    fmt.data_len[7:0] <= rd_data;
				4'd8:    fmt.data_len[15:8] <= rd_data;
				4'd9:    fmt.data_len[23:16] <= rd_data;
				default: fmt.data_len[31:24] <= rd_data;
			endcase
		end
		if (state == dec_check) begin
			fmt.stereo <= (channels != 16'd1);
			fmt.bits16 <= (bits == 8'd16);
		end
	end

endmodule

// ==== rtl/sample_store.sv ====
module sample_store import sample_player_pkg::*; (
	input  logic                clk_sys,
	input  logic                rst,
	input  logic                wr_en,
	input  logic [STORE_AW-1:0] wr_addr,
	input  logic [7:0]          wr_data,
	input  logic                rd_req,
	input  logic [STORE_AW-1:0] rd_addr,
	output logic                rd_ack,
	output logic [7:0]          rd_data
);

	logic [7:0] mem [0:(1 << STORE_AW) - 1];

	logic                req_seen;   // last rd_req level taken
	logic                stage_vld;  // request in flight, second cycle next
	logic [STORE_AW-1:0] stage_addr;

	always_ff @(posedge clk_sys) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// two-stage read, toggle in and toggle out
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			req_seen <= 1'b0;
			stage_vld <= 1'b0;
			rd_ack <= 1'b0;
		end else begin
			req_seen <= rd_req;
			stage_vld <= (rd_req != req_seen);
			if (stage_vld)
				rd_ack <= ~rd_ack;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rd_req != req_seen)
			stage_addr <= rd_addr;
		if (stage_vld)
			rd_data <= mem[stage_addr]; // held until the next request lands
	end

endmodule

// ==== rtl/sample_loader.sv ====
module sample_loader import sample_player_pkg::*; (
	input  logic                clk_sys,
	input  logic                rst,
	input  logic                ioctl_download,
	input  logic                ioctl_wr,
	input  logic [24:0]         ioctl_addr,
	input  logic [7:0]          ioctl_index,
	input  logic [7:0]          ioctl_dout,
	output logic                wr_en,
	output logic [STORE_AW-1:0] wr_addr,
	output logic [7:0]          wr_data,
	output logic                wav_loaded
);

	logic wav_dl;
	logic wav_dl_q;
	logic in_range;

	assign wav_dl = ioctl_download && (ioctl_index == WAV_INDEX);
	assign in_range = (ioctl_addr[24:STORE_AW] == '0); // drop bytes past the store

	assign wr_en = wav_dl && ioctl_wr && in_range;
	assign wr_addr = ioctl_addr[STORE_AW-1:0];
	assign wr_data = ioctl_dout;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wav_dl_q <= 1'b0;
			wav_loaded <= 1'b0;
		end else begin
			wav_dl_q <= wav_dl;
			if (wav_dl && !wav_dl_q)
				wav_loaded <= 1'b0; // new file coming in
			else if (!wav_dl && wav_dl_q)
				wav_loaded <= 1'b1;
		end
	end

endmodule

// ==== rtl/sample_player_pkg.sv ====
package sample_player_pkg;

	localparam int CLK_HZ = 1000000;      // clk_sys rate seen by the stepper
	localparam int STORE_AW = 12;         // 4 KiB sample store
	localparam logic [7:0] WAV_INDEX = 8'd2;
	localparam int HDR_BYTES = 44;        // first data byte of a canonical wav

	// format fields pulled out of the wav header
	typedef struct packed {
		logic        stereo;
		logic        bits16;
		logic [31:0] sample_rate;
		logic [31:0] data_len;
	} wav_format_t;

	// one fetched sample, bytes already in order
	typedef struct packed {
		logic        valid;
		logic        bits16;
		logic [15:0] raw;
	} pcm_t;

	typedef enum logic [2:0] {
		dec_idle,
		dec_fetch,
		dec_wait_ack,
		dec_check,
		dec_ready,
		dec_bad
	} decode_state_e;

	typedef enum logic [2:0] {
		step_idle,
		step_wait_tick,
		step_fetch_lo,
		step_fetch_hi,
		step_skip
	} step_state_e;

endpackage
